// File: all.f
common/noc_pkg.sv
fifo_buffer/fifo_ram.sv
fifo_buffer/min_depth_finder.sv
fifo_buffer/fifo_buffer.sv
rtl/route_compute.sv
rtl/vc_read_arbiter.sv
rtl/input_port.sv
testbench/input_port_tb.sv

// File: common/noc_pkg.sv
`default_nettype none

package noc_pkg;

	// flit kind, carried next to the payload in the buffer RAM
	typedef enum logic [1:0] {
		FLIT_HEAD   = 2'd0,
		FLIT_BODY   = 2'd1,
		FLIT_TAIL   = 2'd2,
		FLIT_SINGLE = 2'd3 // head and tail in one flit
	} flit_type_t;

	// output direction picked by XY routing
	typedef enum logic [2:0] {
		PORT_LOCAL = 3'd0,
		PORT_EAST  = 3'd1,
		PORT_NORTH = 3'd2,
		PORT_WEST  = 3'd3,
		PORT_SOUTH = 3'd4
	} port_t;

	localparam int FLIT_TYPE_WIDTH = 2; // must track flit_type_t

	// index width for n items, never below one bit
	function automatic int clog2_min1(input int n);
		return (n <= 1) ? 1 : $clog2(n);
	endfunction

	// one-hot to binary index, OR of the set positions
	// zero input gives index 0
	function automatic int unsigned onehot_to_index(input logic [31:0] onehot);
		int unsigned idx;
		idx = 0;
		for (int i = 0; i < 32; i++) begin
			if (onehot[i])
				idx = idx | i; // only one bit set in valid use
		end
		return idx;
	endfunction

endpackage

`default_nettype wire

// File: fifo_buffer/fifo_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_buffer #(
	parameter int VC_NUM           = 4,
	parameter int BUFFER_PER_VC    = 4,  // power of two
	parameter int PYLD_WIDTH       = 32,
	parameter int ENABLE_MIN_DEPTH = 0
) (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     wr_en,
	input  wire  [VC_NUM-1:0]       wr_vc,      // one-hot
	input  wire noc_pkg::flit_type_t wr_type,
	input  wire  [PYLD_WIDTH-1:0]   wr_payload,
	input  wire                     rd_en,
	input  wire  [VC_NUM-1:0]       rd_vc,      // one-hot
	output noc_pkg::flit_type_t     rd_type,
	output logic [PYLD_WIDTH-1:0]   rd_payload,
	output logic [VC_NUM-1:0]       vc_nearly_full,
	output logic [VC_NUM-1:0]       vc_not_empty,
	output logic [VC_NUM-1:0]       min_depth_vc
);

	import noc_pkg::*;

	localparam int PTR_W    = clog2_min1(BUFFER_PER_VC);
	localparam int DEPTH_W  = $clog2(BUFFER_PER_VC) + 1; // counts 0..BUFFER_PER_VC
	localparam int VC_IDX_W = clog2_min1(VC_NUM);
	localparam int ADDR_W   = VC_IDX_W + PTR_W;
	localparam int DATA_W   = FLIT_TYPE_WIDTH + PYLD_WIDTH; // vc tag not stored

	logic [PTR_W-1:0]    rd_ptr [VC_NUM];
	logic [PTR_W-1:0]    wr_ptr [VC_NUM];
	logic [DEPTH_W-1:0]  depth  [VC_NUM];

	logic [VC_IDX_W-1:0] wr_sel; // binary vc of the write
	logic [VC_IDX_W-1:0] rd_sel;
	logic [ADDR_W-1:0]   wr_addr;
	logic [ADDR_W-1:0]   rd_addr;
	logic [DATA_W-1:0]   ram_wr_data;
	logic [DATA_W-1:0]   ram_rd_data;

	assign wr_sel = VC_IDX_W'(onehot_to_index(32'(wr_vc)));
	assign rd_sel = VC_IDX_W'(onehot_to_index(32'(rd_vc)));

	// vc index picks the region, that vc's pointer the slot
	assign wr_addr = {wr_sel, wr_ptr[wr_sel]};
	assign rd_addr = {rd_sel, rd_ptr[rd_sel]};

	assign ram_wr_data = {wr_type, wr_payload};
	assign rd_type     = flit_type_t'(ram_rd_data[DATA_W-1 -: FLIT_TYPE_WIDTH]);
	assign rd_payload  = ram_rd_data[PYLD_WIDTH-1:0];

	fifo_ram #(
		.DATA_WIDTH (DATA_W),
		.ADDR_WIDTH (ADDR_W)
	) fifo_ram_i (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (ram_wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (ram_rd_data)
	);

	for (genvar v = 0; v < VC_NUM; v++) begin : g_vc
		logic wr_hit; // write lands in this vc
		logic rd_hit;

		assign wr_hit = wr_en & wr_vc[v];
		assign rd_hit = rd_en & rd_vc[v];

		// levels straight from the registered depth
		assign vc_nearly_full[v] = (depth[v] >= DEPTH_W'(BUFFER_PER_VC - 1));
		assign vc_not_empty[v]   = (depth[v] != '0);

		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				wr_ptr[v] <= '0;
				rd_ptr[v] <= '0;
				depth[v]  <= '0;
			end else begin
				if (wr_hit)
					wr_ptr[v] <= wr_ptr[v] + 1'b1; // wraps at region end
				if (rd_hit)
					rd_ptr[v] <= rd_ptr[v] + 1'b1;
				if (wr_hit && !rd_hit)
					depth[v] <= depth[v] + 1'b1;
				else if (rd_hit && !wr_hit)
					depth[v] <= depth[v] - 1'b1;
				// write and read together, depth unchanged
			end
		end
	end

	if (ENABLE_MIN_DEPTH != 0) begin : g_min_depth
		logic [VC_NUM*DEPTH_W-1:0] depth_flat;

		for (genvar v = 0; v < VC_NUM; v++) begin : g_flat
			assign depth_flat[v*DEPTH_W +: DEPTH_W] = depth[v];
		end

		min_depth_finder #(
			.VC_NUM      (VC_NUM),
			.DEPTH_WIDTH (DEPTH_W)
		) min_depth_finder_i (
			.depth_array (depth_flat),
			.min_vc      (min_depth_vc)
		);
	end else begin : g_no_min_depth
		assign min_depth_vc = '0; // flag not built
	end

endmodule

`default_nettype wire

// File: fifo_buffer/fifo_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_ram #(
	parameter int DATA_WIDTH = 34,
	parameter int ADDR_WIDTH = 4
) (
	input  wire                   clk,
	input  wire                   wr_en,
	input  wire  [ADDR_WIDTH-1:0] wr_addr,
	input  wire  [DATA_WIDTH-1:0] wr_data,
	input  wire                   rd_en,
	input  wire  [ADDR_WIDTH-1:0] rd_addr,
	output logic [DATA_WIDTH-1:0] rd_data
);

	logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH]; // all VC regions back to back

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read port
	// same-address read during a write returns the old word
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr]; // holds last word when idle
	end

endmodule

`default_nettype wire

// File: fifo_buffer/min_depth_finder.sv
`timescale 1ns/1ps
`default_nettype none

module min_depth_finder #(
	parameter int VC_NUM      = 4,
	parameter int DEPTH_WIDTH = 3
) (
	input  wire  [VC_NUM*DEPTH_WIDTH-1:0] depth_array, // vc0 in the low bits
	output logic [VC_NUM-1:0]             min_vc       // one-hot
);

	logic [DEPTH_WIDTH-1:0] depth [VC_NUM]; // unpacked view of the flat vector
	logic [VC_NUM-1:0]      win   [VC_NUM]; // win[i][j]: vc i beats vc j

	for (genvar i = 0; i < VC_NUM; i++) begin : g_row
		assign depth[i] = depth_array[i*DEPTH_WIDTH +: DEPTH_WIDTH];

		for (genvar j = 0; j < VC_NUM; j++) begin : g_col
			if (j < i) begin : g_lo
				assign win[i][j] = (depth[i] < depth[j]); // lower index keeps ties
			end else if (j > i) begin : g_hi
				assign win[i][j] = (depth[i] <= depth[j]);
			end else begin : g_self
				assign win[i][j] = 1'b1; // no compare with itself
			end
		end

		// exactly one vc passes every pairwise compare
		assign min_vc[i] = &win[i];
	end

endmodule

`default_nettype wire

// File: rtl/input_port.sv
`timescale 1ns/1ps
`default_nettype none

module input_port #(
	parameter int VC_NUM           = 4,
	parameter int BUFFER_PER_VC    = 4,
	parameter int PYLD_WIDTH       = 32,
	parameter int X_WIDTH          = 3,
	parameter int Y_WIDTH          = 3,
	parameter int CURRENT_X        = 1,
	parameter int CURRENT_Y        = 1,
	parameter int ENABLE_MIN_DEPTH = 0
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      in_wr,
	input  wire  [VC_NUM-1:0]        in_vc,
	input  wire noc_pkg::flit_type_t in_type,
	input  wire  [PYLD_WIDTH-1:0]    in_payload,
	input  wire                      out_stall,
	output logic                     out_valid,
	output noc_pkg::flit_type_t      out_type,
	output logic [PYLD_WIDTH-1:0]    out_payload,
	output logic [VC_NUM-1:0]        out_vc,
	output noc_pkg::port_t           out_port,
	output logic [VC_NUM-1:0]        vc_nearly_full,
	output logic [VC_NUM-1:0]        vc_not_empty,
	output logic [VC_NUM-1:0]        min_depth_vc
);

	import noc_pkg::*;

	logic                  rd_en;
	logic [VC_NUM-1:0]     rd_vc;
	flit_type_t            rd_type;
	logic [PYLD_WIDTH-1:0] rd_payload;
	port_t                 route_front [VC_NUM];
	logic                  route_pop;
	logic [VC_NUM-1:0]     route_pop_vc;

	// flit storage
	fifo_buffer #(
		.VC_NUM           (VC_NUM),
		.BUFFER_PER_VC    (BUFFER_PER_VC),
		.PYLD_WIDTH       (PYLD_WIDTH),
		.ENABLE_MIN_DEPTH (ENABLE_MIN_DEPTH)
	) fifo_buffer_i (
		.clk            (clk),
		.reset          (reset),
		.wr_en          (in_wr),
		.wr_vc          (in_vc),
		.wr_type        (in_type),
		.wr_payload     (in_payload),
		.rd_en          (rd_en),
		.rd_vc          (rd_vc),
		.rd_type        (rd_type),
		.rd_payload     (rd_payload),
		.vc_nearly_full (vc_nearly_full),
		.vc_not_empty   (vc_not_empty),
		.min_depth_vc   (min_depth_vc)
	);

	// lookahead routing, fed by the same writes
	route_compute #(
		.VC_NUM        (VC_NUM),
		.BUFFER_PER_VC (BUFFER_PER_VC),
		.PYLD_WIDTH    (PYLD_WIDTH),
		.X_WIDTH       (X_WIDTH),
		.Y_WIDTH       (Y_WIDTH),
		.CURRENT_X     (CURRENT_X),
		.CURRENT_Y     (CURRENT_Y)
	) route_compute_i (
		.clk          (clk),
		.reset        (reset),
		.wr_en        (in_wr),
		.wr_vc        (in_vc),
		.wr_type      (in_type),
		.wr_payload   (in_payload),
		.route_pop    (route_pop),
		.route_pop_vc (route_pop_vc),
		.route_front  (route_front)
	);

	vc_read_arbiter #(
		.VC_NUM     (VC_NUM),
		.PYLD_WIDTH (PYLD_WIDTH)
	) vc_read_arbiter_i (
		.clk          (clk),
		.reset        (reset),
		.vc_not_empty (vc_not_empty),
		.out_stall    (out_stall),
		.rd_type      (rd_type),
		.rd_payload   (rd_payload),
		.route_front  (route_front),
		.rd_en        (rd_en),
		.rd_vc        (rd_vc),
		.route_pop    (route_pop),
		.route_pop_vc (route_pop_vc),
		.out_valid    (out_valid),
		.out_type     (out_type),
		.out_payload  (out_payload),
		.out_vc       (out_vc),
		.out_port     (out_port)
	);

endmodule

`default_nettype wire

// File: rtl/route_compute.sv
`timescale 1ns/1ps
`default_nettype none

module route_compute #(
	parameter int VC_NUM        = 4,
	parameter int BUFFER_PER_VC = 4,
	parameter int PYLD_WIDTH    = 32,
	parameter int X_WIDTH       = 3,
	parameter int Y_WIDTH       = 3,
	parameter int CURRENT_X     = 1,
	parameter int CURRENT_Y     = 1
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      wr_en,
	input  wire  [VC_NUM-1:0]        wr_vc,
	input  wire noc_pkg::flit_type_t wr_type,
	input  wire  [PYLD_WIDTH-1:0]    wr_payload,
	input  wire                      route_pop,
	input  wire  [VC_NUM-1:0]        route_pop_vc,
	output noc_pkg::port_t           route_front [VC_NUM]
);

	import noc_pkg::*;

	localparam int PTR_W = clog2_min1(BUFFER_PER_VC);

	logic [X_WIDTH-1:0] dest_x;
	logic [Y_WIDTH-1:0] dest_y;
	port_t              xy_port;  // route of the flit being written
	logic               is_head;  // flit opens a packet

	port_t              route_q    [VC_NUM][BUFFER_PER_VC]; // one queue per vc
	logic [PTR_W-1:0]   q_rd_ptr   [VC_NUM];
	logic [PTR_W-1:0]   q_wr_ptr   [VC_NUM];

	assign dest_x  = wr_payload[X_WIDTH-1:0];
	assign dest_y  = wr_payload[X_WIDTH +: Y_WIDTH];
	assign is_head = (wr_type == FLIT_HEAD) || (wr_type == FLIT_SINGLE);

	// XY dimension order, x first
	always_comb begin
		if (dest_x > X_WIDTH'(CURRENT_X))
			xy_port = PORT_EAST;
		else if (dest_x < X_WIDTH'(CURRENT_X))
			xy_port = PORT_WEST;
		else if (dest_y > Y_WIDTH'(CURRENT_Y))
			xy_port = PORT_NORTH;
		else if (dest_y < Y_WIDTH'(CURRENT_Y))
			xy_port = PORT_SOUTH;
		else
			xy_port = PORT_LOCAL; // arrived
	end

	for (genvar v = 0; v < VC_NUM; v++) begin : g_vc
		logic push;
		logic pop;

		assign push = wr_en & wr_vc[v] & is_head;
		assign pop  = route_pop & route_pop_vc[v]; // tail left the port

		assign route_front[v] = route_q[v][q_rd_ptr[v]];

		always_ff @(posedge clk) begin
			if (push)
				route_q[v][q_wr_ptr[v]] <= xy_port;
		end

		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				q_wr_ptr[v] <= '0;
				q_rd_ptr[v] <= '0;
			end else begin
				if (push)
					q_wr_ptr[v] <= q_wr_ptr[v] + 1'b1;
				if (pop)
					q_rd_ptr[v] <= q_rd_ptr[v] + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/vc_read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module vc_read_arbiter #(
	parameter int VC_NUM     = 4,
	parameter int PYLD_WIDTH = 32
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire  [VC_NUM-1:0]        vc_not_empty,
	input  wire                      out_stall,
	input  wire noc_pkg::flit_type_t rd_type,
	input  wire  [PYLD_WIDTH-1:0]    rd_payload,
	input  wire noc_pkg::port_t      route_front [VC_NUM],
	output logic                     rd_en,
	output logic [VC_NUM-1:0]        rd_vc,
	output logic                     route_pop,
	output logic [VC_NUM-1:0]        route_pop_vc,
	output logic                     out_valid,
	output noc_pkg::flit_type_t      out_type,
	output logic [PYLD_WIDTH-1:0]    out_payload,
	output logic [VC_NUM-1:0]        out_vc,
	output noc_pkg::port_t           out_port
);

	import noc_pkg::*;

	localparam int VC_IDX_W = clog2_min1(VC_NUM);

	logic [VC_IDX_W-1:0] rr_ptr;     // first vc to look at
	logic [VC_NUM-1:0]   eligible;
	logic                found;
	logic [VC_IDX_W-1:0] grant_idx;
	logic [VC_IDX_W-1:0] next_ptr;
	logic [VC_IDX_W-1:0] rd_idx;     // binary form of rd_vc
	int unsigned         probe;

	// vc read this cycle still shows its old depth, skip it once
	assign eligible = vc_not_empty & ~(rd_en ? rd_vc : '0);

	// round-robin search from rr_ptr
	always_comb begin
		found     = 1'b0;
		grant_idx = '0;
		probe     = 0;
		for (int k = 0; k < VC_NUM; k++) begin
			probe = (32'(rr_ptr) + k) % VC_NUM;
			if (!found && eligible[probe]) begin
				found     = 1'b1;
				grant_idx = VC_IDX_W'(probe);
			end
		end
	end

	assign next_ptr = (32'(grant_idx) == VC_NUM - 1) ? '0 : grant_idx + 1'b1;
	assign rd_idx   = VC_IDX_W'(onehot_to_index(32'(rd_vc)));

	// read issue, one per cycle at most
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_en  <= 1'b0;
			rd_vc  <= '0;
			rr_ptr <= '0;
		end else begin
			rd_en <= found && !out_stall;
			if (found && !out_stall) begin
				rd_vc  <= VC_NUM'(1) << grant_idx;
				rr_ptr <= next_ptr; // next search starts after the winner
			end
		end
	end

	// output side lines up with the RAM read register
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_vc    <= '0;
		end else begin
			out_valid <= rd_en; // pulse per flit
			if (rd_en)
				out_vc <= rd_vc;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			out_port <= route_front[rd_idx]; // front route of the read vc
	end

	assign out_type    = rd_type;
	assign out_payload = rd_payload;

	// packet done, free its route entry
	assign route_pop    = out_valid && ((rd_type == FLIT_TAIL) || (rd_type == FLIT_SINGLE));
	assign route_pop_vc = out_vc;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the input port testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary -Wno-fatal --top-module input_port_tb -f all.f -o sim_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/sim_top > "$SIM_LOG" 2>&1
sim_status=$?

if grep -q "Something failed" "$SIM_LOG"; then
	echo "simulation failed, see $SIM_LOG"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status, see $SIM_LOG"
	exit 1
fi

echo "simulation passed"
exit 0

// File: testbench/input_port_tb.sv
`timescale 1ns/1ps
`default_nettype none

module input_port_tb;

	import noc_pkg::*;

	localparam int VC_NUM    = 4;
	localparam int BUF_DEPTH = 4;   // entries per vc
	localparam int PYLD_W    = 32;
	localparam int X_W       = 3;
	localparam int Y_W       = 3;
	localparam int CUR_X     = 3;   // router sits at (3,4)
	localparam int CUR_Y     = 4;
	localparam int TIMEOUT   = 400; // cycles allowed per wait

	logic              clk;
	logic              reset;
	logic              in_wr;
	logic [VC_NUM-1:0] in_vc;
	flit_type_t        in_type;
	logic [PYLD_W-1:0] in_payload;
	logic              out_stall;
	logic              out_valid;
	flit_type_t        out_type;
	logic [PYLD_W-1:0] out_payload;
	logic [VC_NUM-1:0] out_vc;
	port_t             out_port;
	logic [VC_NUM-1:0] vc_nearly_full;
	logic [VC_NUM-1:0] vc_not_empty;
	logic [VC_NUM-1:0] min_depth_vc;

	logic [36:0] exp_q [VC_NUM][$]; // {port, type, payload} per vc
	int          sent_cnt [VC_NUM];
	int          rcvd_cnt [VC_NUM];
	int          rcvd_total;
	port_t       last_route [VC_NUM]; // route of the open packet
	logic [31:0] rng;

	input_port #(
		.VC_NUM           (VC_NUM),
		.BUFFER_PER_VC    (BUF_DEPTH),
		.PYLD_WIDTH       (PYLD_W),
		.X_WIDTH          (X_W),
		.Y_WIDTH          (Y_W),
		.CURRENT_X        (CUR_X),
		.CURRENT_Y        (CUR_Y),
		.ENABLE_MIN_DEPTH (1)
	) input_port_i (
		.clk            (clk),
		.reset          (reset),
		.in_wr          (in_wr),
		.in_vc          (in_vc),
		.in_type        (in_type),
		.in_payload     (in_payload),
		.out_stall      (out_stall),
		.out_valid      (out_valid),
		.out_type       (out_type),
		.out_payload    (out_payload),
		.out_vc         (out_vc),
		.out_port       (out_port),
		.vc_nearly_full (vc_nearly_full),
		.vc_not_empty   (vc_not_empty),
		.min_depth_vc   (min_depth_vc)
	);

	always #2 clk = ~clk; // 4 ns period

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// x first and y after
	function automatic port_t xy_route(input logic [X_W-1:0] dx, input logic [Y_W-1:0] dy);
		if (int'(dx) > CUR_X)
			return PORT_EAST;
		else if (int'(dx) < CUR_X)
			return PORT_WEST;
		else if (int'(dy) > CUR_Y)
			return PORT_NORTH;
		else if (int'(dy) < CUR_Y)
			return PORT_SOUTH;
		return PORT_LOCAL;
	endfunction

	function automatic int vc_index(input logic [VC_NUM-1:0] onehot);
		int idx;
		idx = 0;
		for (int i = 0; i < VC_NUM; i++) begin
			if (onehot[i])
				idx = i;
		end
		return idx;
	endfunction

	// lowest-index vc of smallest model depth
	function automatic logic [VC_NUM-1:0] min_vc_model();
		int best;
		best = 0;
		for (int i = 1; i < VC_NUM; i++) begin
			if (sent_cnt[i] - rcvd_cnt[i] < sent_cnt[best] - rcvd_cnt[best])
				best = i;
		end
		return VC_NUM'(1) << best;
	endfunction

	function automatic logic [31:0] dest_payload(input logic [31:0] r,
		input logic [X_W-1:0] dx, input logic [Y_W-1:0] dy);
		return {r[31:X_W+Y_W], dy, dx}; // dest in the low bits
	endfunction

	task automatic report_error(input string msg);
		$display("ERROR %s at %0t", msg, $time);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("FAIL %s got %h expected %h at %0t", name, got, want, $time);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// scoreboard sampling at the falling edge where outputs are stable
	always @(negedge clk) begin : monitor
		int          v;
		logic [36:0] want;
		if (!reset && out_valid) begin
			v = vc_index(out_vc);
			if ($countones(out_vc) != 1)
				report_error("out_vc is not one-hot");
			else if (exp_q[v].size() == 0)
				report_error("flit came out on a vc with no flit expected");
			else begin
				want = exp_q[v].pop_front();
				check_value("out_payload", out_payload, want[31:0]);
				check_value("out_type", 32'(out_type), 32'(want[33:32]));
				check_value("out_port", 32'(out_port), 32'(want[36:34]));
				rcvd_cnt[v]++;
				rcvd_total++;
			end
		end
	end

	// called at a falling edge and returns at the next one
	task automatic send_flit(input int v, input flit_type_t t, input logic [31:0] p);
		int waited;
		waited = 0;
		while (sent_cnt[v] - rcvd_cnt[v] >= BUF_DEPTH) begin // buffer and route queue room
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT)
				report_error("timeout waiting for room in a vc buffer");
		end
		if (t == FLIT_HEAD || t == FLIT_SINGLE)
			last_route[v] = xy_route(p[X_W-1:0], p[X_W +: Y_W]);
		exp_q[v].push_back({last_route[v], t, p}); // body and tail follow the head
		sent_cnt[v]++;
		in_wr      = 1'b1;
		in_vc      = VC_NUM'(1) << v;
		in_type    = t;
		in_payload = p;
		@(negedge clk);
		in_wr = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		int pending;
		waited  = 0;
		pending = 1;
		while (pending != 0) begin
			@(negedge clk);
			pending = 0;
			for (int i = 0; i < VC_NUM; i++)
				pending += sent_cnt[i] - rcvd_cnt[i];
			waited++;
			if (waited > TIMEOUT)
				report_error("timeout waiting for the buffers to drain");
		end
		@(negedge clk);
		check_value("vc_not_empty", 32'(vc_not_empty), 32'h0);
	endtask

	task automatic idle_after_reset();
		for (int v = 0; v < VC_NUM; v++) begin
			@(negedge clk);
			check_value("out_valid", 32'(out_valid), 32'h0);
			check_value("vc_not_empty", 32'(vc_not_empty[v]), 32'h0);
			check_value("vc_nearly_full", 32'(vc_nearly_full[v]), 32'h0);
		end
	endtask

	task automatic single_vc_order();
		logic [X_W-1:0] dx [5];
		logic [Y_W-1:0] dy [5];
		dx = '{3, 6, 0, 3, 3}; // local, east, west, north, south
		dy = '{4, 1, 7, 7, 0};
		for (int i = 0; i < 5; i++) begin
			rng = lcg(rng);
			send_flit(2, FLIT_SINGLE, dest_payload(rng, dx[i], dy[i]));
		end
		wait_drain();
	endtask

	task automatic interleaved_packets();
		int          len [VC_NUM];
		flit_type_t  t;
		for (int r = 0; r < 6; r++) begin
			for (int v = 0; v < VC_NUM; v++) begin
				rng = lcg(rng);
				len[v] = 1 + int'(rng[31:28]) % 3; // 1 to 3 flits
			end
			for (int f = 0; f < 3; f++) begin
				for (int v = 0; v < VC_NUM; v++) begin
					if (f < len[v]) begin
						rng = lcg(rng);
						if (len[v] == 1)
							t = FLIT_SINGLE;
						else if (f == 0)
							t = FLIT_HEAD;
						else if (f == len[v] - 1)
							t = FLIT_TAIL;
						else
							t = FLIT_BODY;
						send_flit(v, t, {rng[25:0], rng[31:26]}); // high lcg bits in dest
					end
				end
			end
		end
		wait_drain();
	endtask

	task automatic fill_one_vc();
		logic [VC_NUM-1:0] bit_vc;
		logic [VC_NUM-1:0] want_full;
		bit_vc    = VC_NUM'(1) << 1;
		out_stall = 1'b1;
		@(negedge clk);
		for (int k = 1; k < BUF_DEPTH; k++) begin
			rng = lcg(rng);
			send_flit(1, FLIT_SINGLE, {rng[25:0], rng[31:26]});
			want_full = (sent_cnt[1] - rcvd_cnt[1] >= BUF_DEPTH - 1) ? bit_vc : '0;
			check_value("vc_not_empty", 32'(vc_not_empty), 32'(bit_vc));
			check_value("vc_nearly_full", 32'(vc_nearly_full), 32'(want_full));
		end
		out_stall = 1'b0;
		wait_drain();
	endtask

	task automatic stall_mid_traffic();
		int snap;
		for (int i = 0; i < 8; i++) begin
			rng = lcg(rng);
			send_flit(i % VC_NUM, FLIT_SINGLE, {rng[25:0], rng[31:26]});
		end
		out_stall = 1'b1;
		@(posedge clk);
		snap = rcvd_total;
		@(negedge clk);
		for (int v = 0; v < VC_NUM; v++) begin // more writes while stalled
			rng = lcg(rng);
			send_flit(v, FLIT_SINGLE, {rng[25:0], rng[31:26]});
		end
		repeat (6) @(posedge clk);
		if (rcvd_total - snap > 1)
			report_error("more than one flit came out after the stall was raised");
		@(negedge clk);
		out_stall = 1'b0;
		wait_drain();
	endtask

	task automatic min_depth_ranking();
		int order [9];
		order     = '{0, 0, 1, 2, 2, 2, 3, 1, 3}; // covers ties and moves of the minimum
		out_stall = 1'b1;
		@(negedge clk);
		check_value("min_depth_vc", 32'(min_depth_vc), 32'(min_vc_model()));
		for (int i = 0; i < 9; i++) begin
			rng = lcg(rng);
			send_flit(order[i], FLIT_SINGLE, {rng[25:0], rng[31:26]});
			check_value("min_depth_vc", 32'(min_depth_vc), 32'(min_vc_model()));
		end
		out_stall = 1'b0;
		wait_drain();
	endtask

	initial begin
		clk        = 1'b0;
		reset      = 1'b1;
		in_wr      = 1'b0;
		in_vc      = '0;
		in_type    = FLIT_HEAD;
		in_payload = '0;
		out_stall  = 1'b0;
		rng        = 32'h6142_d67a;
		rcvd_total = 0;
		for (int v = 0; v < VC_NUM; v++) begin
			sent_cnt[v]   = 0;
			rcvd_cnt[v]   = 0;
			last_route[v] = PORT_LOCAL;
		end
		repeat (8) @(negedge clk);
		reset = 1'b0;
		idle_after_reset();
		single_vc_order();
		interleaved_packets();
		fill_one_vc();
		stall_mid_traffic();
		min_depth_ranking();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
